/* hw/cpu_mem_pkg.sv */
package cpu_mem_pkg;

    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;
    localparam int ID_W = 4;

    // Instruction cache geometry
    localparam int LINE_WORDS = 8;
    localparam int OFFSET_W = 5;
    localparam int INDEX_W = 7;
    localparam int TAG_W = 20;

    // Uncached fetches before the cache opens
    localparam int CACHE_WARMUP = 3;
    // kseg1
    localparam logic [2:0] UNCACHED_SEG = 3'b101;

    localparam logic [ID_W-1:0] ID_BRIDGE = 4'd0;
    localparam logic [ID_W-1:0] ID_ICACHE = 4'd1;

    typedef enum logic [1:0] {
        SIZE_BYTE = 2'b00,
        SIZE_HALF = 2'b01,
        SIZE_WORD = 2'b10
    } access_size_e;

    typedef struct packed {
        logic              req;
        logic              wr;
        access_size_e      size;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } sram_req_t;

    typedef struct packed {
        logic              addr_ok;
        logic              data_ok;
        logic [DATA_W-1:0] rdata;
    } sram_resp_t;

    typedef struct packed {
        logic [ID_W-1:0]     arid;
        logic [ADDR_W-1:0]   araddr;
        logic [3:0]          arlen;
        logic [2:0]          arsize;
        logic [1:0]          arburst;
        logic [1:0]          arlock;
        logic [3:0]          arcache;
        logic [2:0]          arprot;
        logic                arvalid;
        logic                rready;
        logic [ID_W-1:0]     awid;
        logic [ADDR_W-1:0]   awaddr;
        logic [3:0]          awlen;
        logic [2:0]          awsize;
        logic [1:0]          awburst;
        logic [1:0]          awlock;
        logic [3:0]          awcache;
        logic [2:0]          awprot;
        logic                awvalid;
        logic [ID_W-1:0]     wid;
        logic [DATA_W-1:0]   wdata;
        logic [DATA_W/8-1:0] wstrb;
        logic                wlast;
        logic                wvalid;
        logic                bready;
    } axi_req_t;

    typedef struct packed {
        logic              arready;
        logic [ID_W-1:0]   rid;
        logic [DATA_W-1:0] rdata;
        logic [1:0]        rresp;
        logic              rlast;
        logic              rvalid;
        logic              awready;
        logic              wready;
        logic [ID_W-1:0]   bid;
        logic [1:0]        bresp;
        logic              bvalid;
    } axi_resp_t;

    typedef enum logic [2:0] {
        BR_IDLE,
        BR_AR,
        BR_R,
        BR_AW_W,
        BR_B
    } bridge_state_e;

    typedef enum logic [2:0] {
        IC_SWEEP,
        IC_LOOKUP,
        IC_AR,
        IC_REFILL,
        IC_RESPOND
    } icache_state_e;

endpackage

/* hw/fetch_router.sv */
`timescale 1ns/10ps

module fetch_router import cpu_mem_pkg::*; (
    input  logic       Clk,
    input  logic       aresetn,

    input  sram_req_t  inst_req_i,
    output sram_resp_t inst_resp_o,

    output sram_req_t  ic_req_o,
    input  sram_resp_t ic_resp_i,
    output sram_req_t  br_req_o,
    input  sram_resp_t br_resp_i
);

    logic [$clog2(CACHE_WARMUP + 1)-1:0] warm_cnt;
    logic cache_open;
    logic go_bridge;
    logic pending_q;
    logic owner_br_q;
    logic accept;
    logic done;

    assign cache_open = (warm_cnt == CACHE_WARMUP);
    assign go_bridge  = (inst_req_i.addr[ADDR_W-1:ADDR_W-3] == UNCACHED_SEG) || !cache_open;

    // Only one fetch in flight, so new requests wait for the reply
    always_comb begin
        ic_req_o     = inst_req_i;
        br_req_o     = inst_req_i;
        ic_req_o.req = inst_req_i.req && !pending_q && !go_bridge;
        br_req_o.req = inst_req_i.req && !pending_q && go_bridge;
    end

    assign accept = !pending_q && (go_bridge ? br_resp_i.addr_ok : ic_resp_i.addr_ok);
    assign done   = pending_q && (owner_br_q ? br_resp_i.data_ok : ic_resp_i.data_ok);

    assign inst_resp_o.addr_ok = accept;
    assign inst_resp_o.data_ok = done;
    assign inst_resp_o.rdata   = owner_br_q ? br_resp_i.rdata : ic_resp_i.rdata;

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            pending_q  <= 1'b0;
            owner_br_q <= 1'b1;
            warm_cnt   <= '0;
        end else begin
            if (accept) begin
                pending_q  <= 1'b1;
                owner_br_q <= go_bridge;
            end else if (done) begin
                pending_q <= 1'b0;
            end
            // Warmup counts completed uncached fetches
            if (done && owner_br_q && !cache_open) begin
                warm_cnt <= warm_cnt + 1'b1;
            end
        end
    end

endmodule

/* hw/sram_axi_bridge.sv */
`timescale 1ns/10ps

module sram_axi_bridge import cpu_mem_pkg::*; (
    input  logic       Clk,
    input  logic       aresetn,

    input  sram_req_t  inst_req_i,
    output sram_resp_t inst_resp_o,
    input  sram_req_t  data_req_i,
    output sram_resp_t data_resp_o,

    output axi_req_t   axi_req_o,
    input  axi_resp_t  axi_resp_i
);

    bridge_state_e state;
    logic take_data;
    logic take_inst;
    sram_req_t cur;
    logic [DATA_W/8-1:0] strb;

    logic sel_data_q;
    logic done_q;
    logic aw_pend;
    logic w_pend;
    logic [ADDR_W-1:0] addr_q;
    access_size_e size_q;
    logic [DATA_W-1:0] wdata_q;
    logic [DATA_W/8-1:0] wstrb_q;
    logic [DATA_W-1:0] rdata_q;

    // Data channel has priority
    assign take_data = (state == BR_IDLE) && data_req_i.req;
    assign take_inst = (state == BR_IDLE) && inst_req_i.req && !data_req_i.req;
    assign cur = take_data ? data_req_i : inst_req_i;

    always_comb begin
        case (cur.size)
            SIZE_BYTE: strb = 4'b0001 << cur.addr[1:0];
            SIZE_HALF: strb = 4'b0011 << cur.addr[1:0];
            default:   strb = 4'b1111;
        endcase
    end

    assign data_resp_o.addr_ok = take_data;
    assign data_resp_o.data_ok = done_q && sel_data_q;
    assign data_resp_o.rdata   = rdata_q;
    assign inst_resp_o.addr_ok = take_inst;
    assign inst_resp_o.data_ok = done_q && !sel_data_q;
    assign inst_resp_o.rdata   = rdata_q;

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            state      <= BR_IDLE;
            sel_data_q <= 1'b0;
            done_q     <= 1'b0;
            aw_pend    <= 1'b0;
            w_pend     <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                BR_IDLE: begin
                    if (take_data || take_inst) begin
                        sel_data_q <= take_data;
                        aw_pend    <= cur.wr;
                        w_pend     <= cur.wr;
                        state      <= cur.wr ? BR_AW_W : BR_AR;
                    end
                end
                BR_AR: if (axi_resp_i.arready) state <= BR_R;
                BR_R: begin
                    if (axi_resp_i.rvalid) begin
                        done_q <= 1'b1;
                        state  <= BR_IDLE;
                    end
                end
                BR_AW_W: begin
                    if (axi_resp_i.awready) aw_pend <= 1'b0;
                    if (axi_resp_i.wready) w_pend <= 1'b0;
                    if ((!aw_pend || axi_resp_i.awready) && (!w_pend || axi_resp_i.wready)) begin
                        state <= BR_B;
                    end
                end
                BR_B: begin
                    if (axi_resp_i.bvalid) begin
                        done_q <= 1'b1;
                        state  <= BR_IDLE;
                    end
                end
                default: state <= BR_IDLE;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (take_data || take_inst) begin
            addr_q  <= cur.addr;
            size_q  <= cur.size;
            wdata_q <= cur.wdata << {cur.addr[1:0], 3'b000};
            wstrb_q <= strb;
        end
        if (state == BR_R && axi_resp_i.rvalid) rdata_q <= axi_resp_i.rdata;
    end

    always_comb begin
        axi_req_o         = '0;
        axi_req_o.arid    = ID_BRIDGE;
        axi_req_o.araddr  = addr_q;
        axi_req_o.arsize  = {1'b0, size_q};
        axi_req_o.arburst = 2'b01;
        axi_req_o.arvalid = (state == BR_AR);
        axi_req_o.rready  = (state == BR_R);
        axi_req_o.awid    = ID_BRIDGE;
        axi_req_o.awaddr  = addr_q;
        axi_req_o.awsize  = {1'b0, size_q};
        axi_req_o.awburst = 2'b01;
        axi_req_o.awvalid = aw_pend;
        axi_req_o.wid     = ID_BRIDGE;
        axi_req_o.wdata   = wdata_q;
        axi_req_o.wstrb   = wstrb_q;
        axi_req_o.wlast   = 1'b1;
        axi_req_o.wvalid  = w_pend;
        axi_req_o.bready  = (state == BR_B);
    end

endmodule

/* hw/icache.sv */
`timescale 1ns/10ps

module icache import cpu_mem_pkg::*; (
    input  logic       Clk,
    input  logic       aresetn,

    input  sram_req_t  req_i,
    output sram_resp_t resp_o,

    output axi_req_t   axi_req_o,
    input  axi_resp_t  axi_resp_i
);

    icache_state_e state;

    logic                  valid_mem [2**INDEX_W];
    logic [TAG_W-1:0]      tag_mem   [2**INDEX_W];
    logic [DATA_W-1:0]     data_mem  [2**(INDEX_W+OFFSET_W-2)];

    logic [INDEX_W-1:0]    sweep_idx;
    logic [OFFSET_W-3:0]   beat;
    logic [ADDR_W-1:0]     addr_q;

    logic [INDEX_W-1:0]    req_idx;
    logic [TAG_W-1:0]      req_tag;
    logic [INDEX_W-1:0]    idx_q;
    logic [TAG_W-1:0]      tag_q;
    logic [OFFSET_W-3:0]   word_q;
    logic                  hit;
    logic                  accept;
    logic                  beat_fire;
    logic                  refill_last;

    assign req_idx = req_i.addr[OFFSET_W+INDEX_W-1:OFFSET_W];
    assign req_tag = req_i.addr[ADDR_W-1:ADDR_W-TAG_W];
    assign idx_q   = addr_q[OFFSET_W+INDEX_W-1:OFFSET_W];
    assign tag_q   = addr_q[ADDR_W-1:ADDR_W-TAG_W];
    assign word_q  = addr_q[OFFSET_W-1:2];

    assign hit    = valid_mem[req_idx] && (tag_mem[req_idx] == req_tag);
    assign accept = (state == IC_LOOKUP) && req_i.req;

    assign beat_fire   = (state == IC_REFILL) && axi_resp_i.rvalid;
    assign refill_last = beat_fire && axi_resp_i.rlast;

    // Reply always comes from the stored line
    assign resp_o.addr_ok = accept;
    assign resp_o.data_ok = (state == IC_RESPOND);
    assign resp_o.rdata   = data_mem[{idx_q, word_q}];

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            state     <= IC_SWEEP;
            sweep_idx <= '0;
            beat      <= '0;
        end else begin
            case (state)
                IC_SWEEP: begin
                    sweep_idx <= sweep_idx + 1'b1;
                    if (&sweep_idx) state <= IC_LOOKUP;
                end
                IC_LOOKUP: begin
                    if (accept) state <= hit ? IC_RESPOND : IC_AR;
                end
                IC_AR: begin
                    beat <= '0;
                    if (axi_resp_i.arready) state <= IC_REFILL;
                end
                IC_REFILL: begin
                    if (beat_fire) beat <= beat + 1'b1;
                    if (refill_last) state <= IC_RESPOND;
                end
                IC_RESPOND: state <= IC_LOOKUP;
                default: state <= IC_LOOKUP;
            endcase
        end
    end

    always_ff @(posedge Clk) begin
        if (accept) addr_q <= req_i.addr;
        // One set cleared per cycle after reset
        if (state == IC_SWEEP) begin
            valid_mem[sweep_idx] <= 1'b0;
        end else if (refill_last) begin
            valid_mem[idx_q] <= 1'b1;
            tag_mem[idx_q]   <= tag_q;
        end
        if (beat_fire) data_mem[{idx_q, beat}] <= axi_resp_i.rdata;
    end

    always_comb begin
        axi_req_o         = '0;
        axi_req_o.arid    = ID_ICACHE;
        axi_req_o.araddr  = {addr_q[ADDR_W-1:OFFSET_W], {OFFSET_W{1'b0}}};
        axi_req_o.arlen   = 4'(LINE_WORDS - 1);
        axi_req_o.arsize  = 3'b010;
        axi_req_o.arburst = 2'b01;
        axi_req_o.arvalid = (state == IC_AR);
        axi_req_o.rready  = (state == IC_REFILL);
    end

endmodule

/* hw/axi_read_arbiter.sv */
`timescale 1ns/10ps

module axi_read_arbiter import cpu_mem_pkg::*; (
    input  logic      Clk,
    input  logic      aresetn,

    input  axi_req_t  br_req_i,
    output axi_resp_t br_resp_o,
    input  axi_req_t  ic_req_i,
    output axi_resp_t ic_resp_o,

    output axi_req_t  axi_req_o,
    input  axi_resp_t axi_resp_i
);

    logic busy_q;
    logic grant_ic_q;
    logic sel_ic;
    logic ar_fire;
    logic r_done;

    // Bridge wins a tie, grant held until rlast
    assign sel_ic = busy_q ? grant_ic_q : (ic_req_i.arvalid && !br_req_i.arvalid);

    always_comb begin
        axi_req_o = br_req_i;
        if (sel_ic) begin
            axi_req_o.arid    = ic_req_i.arid;
            axi_req_o.araddr  = ic_req_i.araddr;
            axi_req_o.arlen   = ic_req_i.arlen;
            axi_req_o.arsize  = ic_req_i.arsize;
            axi_req_o.arburst = ic_req_i.arburst;
            axi_req_o.arlock  = ic_req_i.arlock;
            axi_req_o.arcache = ic_req_i.arcache;
            axi_req_o.arprot  = ic_req_i.arprot;
        end
        axi_req_o.arvalid = !busy_q && (sel_ic ? ic_req_i.arvalid : br_req_i.arvalid);
        axi_req_o.rready  = busy_q && (grant_ic_q ? ic_req_i.rready : br_req_i.rready);
    end

    always_comb begin
        br_resp_o         = axi_resp_i;
        ic_resp_o         = axi_resp_i;
        br_resp_o.arready = !busy_q && !sel_ic && axi_resp_i.arready;
        ic_resp_o.arready = !busy_q && sel_ic && axi_resp_i.arready;
        br_resp_o.rvalid  = busy_q && !grant_ic_q && axi_resp_i.rvalid;
        br_resp_o.rlast   = busy_q && !grant_ic_q && axi_resp_i.rlast;
        ic_resp_o.rvalid  = busy_q && grant_ic_q && axi_resp_i.rvalid;
        ic_resp_o.rlast   = busy_q && grant_ic_q && axi_resp_i.rlast;
        // The cache never writes
        ic_resp_o.awready = 1'b0;
        ic_resp_o.wready  = 1'b0;
        ic_resp_o.bvalid  = 1'b0;
    end

    assign ar_fire = axi_req_o.arvalid && axi_resp_i.arready;
    assign r_done  = axi_req_o.rready && axi_resp_i.rvalid && axi_resp_i.rlast;

    always_ff @(posedge Clk) begin
        if (!aresetn) begin
            busy_q     <= 1'b0;
            grant_ic_q <= 1'b0;
        end else if (ar_fire) begin
            busy_q     <= 1'b1;
            grant_ic_q <= sel_ic;
        end else if (r_done) begin
            busy_q <= 1'b0;
        end
    end

endmodule

/* hw/cpu_mem_top.sv */
`timescale 1ns/10ps

module cpu_mem_top import cpu_mem_pkg::*; (
    input  logic       Clk,
    input  logic       aresetn,

    input  sram_req_t  inst_req_i,
    output sram_resp_t inst_resp_o,
    input  sram_req_t  data_req_i,
    output sram_resp_t data_resp_o,

    output axi_req_t   axi_req_o,
    input  axi_resp_t  axi_resp_i
);

    sram_req_t  ic_req;
    sram_resp_t ic_resp;
    sram_req_t  br_inst_req;
    sram_resp_t br_inst_resp;

    axi_req_t   br_axi_req;
    axi_resp_t  br_axi_resp;
    axi_req_t   ic_axi_req;
    axi_resp_t  ic_axi_resp;

    fetch_router u_fetch_router (
        .Clk         (Clk),
        .aresetn     (aresetn),
        .inst_req_i  (inst_req_i),
        .inst_resp_o (inst_resp_o),
        .ic_req_o    (ic_req),
        .ic_resp_i   (ic_resp),
        .br_req_o    (br_inst_req),
        .br_resp_i   (br_inst_resp)
    );

    icache u_icache (
        .Clk        (Clk),
        .aresetn    (aresetn),
        .req_i      (ic_req),
        .resp_o     (ic_resp),
        .axi_req_o  (ic_axi_req),
        .axi_resp_i (ic_axi_resp)
    );

    sram_axi_bridge u_bridge (
        .Clk         (Clk),
        .aresetn     (aresetn),
        .inst_req_i  (br_inst_req),
        .inst_resp_o (br_inst_resp),
        .data_req_i  (data_req_i),
        .data_resp_o (data_resp_o),
        .axi_req_o   (br_axi_req),
        .axi_resp_i  (br_axi_resp)
    );

    axi_read_arbiter u_arbiter (
        .Clk        (Clk),
        .aresetn    (aresetn),
        .br_req_i   (br_axi_req),
        .br_resp_o  (br_axi_resp),
        .ic_req_i   (ic_axi_req),
        .ic_resp_o  (ic_axi_resp),
        .axi_req_o  (axi_req_o),
        .axi_resp_i (axi_resp_i)
    );

endmodule

/* tests/axi_slave_mem.sv */
`timescale 1ns/10ps

module axi_slave_mem import cpu_mem_pkg::*; (
    input  logic      Clk,
    input  logic      aresetn,
    input  axi_req_t  axi_req_i,
    output axi_resp_t axi_resp_o
);

    logic [7:0]      mem [65536];
    logic [31:0]     lfsr;
    logic            rd_busy;
    logic [15:0]     rd_addr;
    logic [3:0]      rd_left;
    logic [ID_W-1:0] rd_id;
    logic            aw_held;
    logic            w_held;
    logic            b_pend;
    logic [15:0]     wr_addr;
    logic [31:0]     wr_data;
    logic [3:0]      wr_strb;
    logic [ID_W-1:0] wr_id;

    // Galois LFSR, one step per bit
    function automatic logic next_rand_bit();
        logic b;
        b = lfsr[0];
        lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
        return b;
    endfunction

    initial begin
        for (int i = 0; i < 65536; i++) begin
            mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        lfsr = 32'h397e;
        axi_resp_o = '0;
        rd_busy = 1'b0;
        aw_held = 1'b0;
        w_held = 1'b0;
        b_pend = 1'b0;
    end

    always @(posedge Clk) begin
        axi_resp_t old;
        axi_resp_t nxt;
        old = axi_resp_o;
        nxt = axi_resp_o;
        if (!aresetn) begin
            nxt = '0;
            rd_busy = 1'b0;
            aw_held = 1'b0;
            w_held = 1'b0;
            b_pend = 1'b0;
        end else begin
            if (old.rvalid && axi_req_i.rready) begin
                if (old.rlast) begin
                    rd_busy = 1'b0;
                end else begin
                    rd_addr = rd_addr + 16'd4;
                    rd_left = rd_left - 4'd1;
                end
            end
            if (old.arready && axi_req_i.arvalid) begin
                rd_busy = 1'b1;
                rd_addr = {axi_req_i.araddr[15:2], 2'b00};
                rd_left = axi_req_i.arlen;
                rd_id = axi_req_i.arid;
            end
            if (old.bvalid && axi_req_i.bready) begin
                aw_held = 1'b0;
                w_held = 1'b0;
                b_pend = 1'b0;
            end
            if (old.awready && axi_req_i.awvalid) begin
                aw_held = 1'b1;
                wr_addr = {axi_req_i.awaddr[15:2], 2'b00};
                wr_id = axi_req_i.awid;
            end
            if (old.wready && axi_req_i.wvalid) begin
                w_held = 1'b1;
                wr_data = axi_req_i.wdata;
                wr_strb = axi_req_i.wstrb;
            end
            if (aw_held && w_held && !b_pend) begin
                for (int l = 0; l < 4; l++) begin
                    if (wr_strb[l]) mem[wr_addr + 16'(l)] = wr_data[l*8 +: 8];
                end
                b_pend = 1'b1;
            end
            nxt.arready = !rd_busy && next_rand_bit();
            nxt.awready = !aw_held && next_rand_bit();
            nxt.wready = !w_held && next_rand_bit();
            if (!(old.rvalid && !axi_req_i.rready)) begin
                nxt.rvalid = rd_busy && next_rand_bit();
            end
            nxt.rid = rd_id;
            nxt.rresp = 2'b00;
            nxt.rlast = (rd_left == 4'd0);
            nxt.rdata = {mem[rd_addr + 16'd3], mem[rd_addr + 16'd2],
                         mem[rd_addr + 16'd1], mem[rd_addr]};
            if (!(old.bvalid && !axi_req_i.bready)) begin
                nxt.bvalid = b_pend && next_rand_bit();
            end
            nxt.bid = wr_id;
            nxt.bresp = 2'b00;
        end
        #1;
        axi_resp_o = nxt;
    end

endmodule

/* tests/tb_cpu_mem.sv */
`timescale 1ns/10ps

module tb_cpu_mem import cpu_mem_pkg::*; ();

    // Cycle limit for the whole run
    localparam int TIMEOUT_CYCLES = 20000;

    logic       Clk;
    logic       aresetn;
    sram_req_t  inst_req;
    sram_resp_t inst_resp;
    sram_req_t  data_req;
    sram_resp_t data_resp;
    axi_req_t   axi_req;
    axi_resp_t  axi_resp;

    logic [7:0]  ref_mem [65536];
    logic [31:0] lfsr;
    int          errors;
    int          tests;
    int          cycles;
    int          err_at_start;
    int          inst_pend;
    int          data_pend;
    logic        reset_d;
    logic [31:0] inst_exp;
    logic [31:0] data_exp;
    logic        data_is_load;
    logic        ar_check;
    logic [3:0]  exp_arid;
    logic [3:0]  exp_arlen;
    logic [31:0] exp_araddr;
    logic        aw_check;
    logic [2:0]  exp_awsize;
    logic [3:0]  exp_wstrb;
    logic        no_ar;

    cpu_mem_top dut_i (
        .Clk         (Clk),
        .aresetn     (aresetn),
        .inst_req_i  (inst_req),
        .inst_resp_o (inst_resp),
        .data_req_i  (data_req),
        .data_resp_o (data_resp),
        .axi_req_o   (axi_req),
        .axi_resp_i  (axi_resp)
    );

    axi_slave_mem u_mem (
        .Clk        (Clk),
        .aresetn    (aresetn),
        .axi_req_i  (axi_req),
        .axi_resp_o (axi_resp)
    );

    always #20 Clk = ~Clk;

    task automatic value_error(input string name, input logic [31:0] exp, input logic [31:0] act);
        $display("FAILED at %0t: %s expected %h actual %h", $time, name, exp, act);
        errors++;
    endtask

    task automatic flag_error(input string msg);
        $display("Error at %0t: %s", $time, msg);
        errors++;
    endtask

    always @(posedge Clk) begin
        reset_d <= aresetn;
        if (!aresetn) begin
            inst_pend <= 0;
            data_pend <= 0;
        end else begin
            inst_pend <= inst_pend + int'(inst_resp.addr_ok) - int'(inst_resp.data_ok);
            data_pend <= data_pend + int'(data_resp.addr_ok) - int'(data_resp.data_ok);
        end
    end

    // Reset and the first cycle after it
    assert property (@(posedge Clk) (!aresetn || !reset_d) |->
        !(axi_req.arvalid || axi_req.awvalid || axi_req.wvalid || inst_resp.addr_ok ||
          inst_resp.data_ok || data_resp.addr_ok || data_resp.data_ok))
        else flag_error("valid or handshake output high around reset");

    assert property (@(posedge Clk) inst_resp.data_ok |-> inst_resp.rdata == inst_exp)
        else value_error("inst_resp.rdata", inst_exp, inst_resp.rdata);
    assert property (@(posedge Clk) data_resp.data_ok && data_is_load |->
        data_resp.rdata == data_exp)
        else value_error("data_resp.rdata", data_exp, data_resp.rdata);
    assert property (@(posedge Clk) inst_resp.data_ok |-> inst_pend == 1)
        else flag_error("instruction data_ok without one accepted request");
    assert property (@(posedge Clk) data_resp.data_ok |-> data_pend == 1)
        else flag_error("data data_ok without one accepted request");

    assert property (@(posedge Clk) ar_check && axi_req.arvalid && axi_resp.arready |->
        axi_req.arid == exp_arid)
        else value_error("arid", 32'(exp_arid), 32'(axi_req.arid));
    assert property (@(posedge Clk) ar_check && axi_req.arvalid && axi_resp.arready |->
        axi_req.arlen == exp_arlen)
        else value_error("arlen", 32'(exp_arlen), 32'(axi_req.arlen));
    assert property (@(posedge Clk) ar_check && axi_req.arvalid && axi_resp.arready |->
        axi_req.araddr == exp_araddr)
        else value_error("araddr", exp_araddr, axi_req.araddr);
    assert property (@(posedge Clk) no_ar |-> !(axi_req.arvalid && axi_resp.arready))
        else flag_error("read address handshake during a cache hit");

    assert property (@(posedge Clk) aw_check && axi_req.awvalid && axi_resp.awready |->
        axi_req.awsize == exp_awsize)
        else value_error("awsize", 32'(exp_awsize), 32'(axi_req.awsize));
    assert property (@(posedge Clk) aw_check && axi_req.wvalid && axi_resp.wready |->
        axi_req.wstrb == exp_wstrb)
        else value_error("wstrb", 32'(exp_wstrb), 32'(axi_req.wstrb));

    always @(posedge Clk) begin
        cycles++;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("Timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("SIMULATION FAILED");
            $finish;
        end
    end

    function automatic logic [31:0] ref_word(input logic [31:0] addr);
        logic [15:0] a;
        a = {addr[15:2], 2'b00};
        return {ref_mem[a + 16'd3], ref_mem[a + 16'd2], ref_mem[a + 16'd1], ref_mem[a]};
    endfunction

    function automatic logic [31:0] lfsr_bits(input int n);
        logic [31:0] v;
        logic b;
        v = '0;
        for (int i = 0; i < n; i++) begin
            b = lfsr[0];
            lfsr = {1'b0, lfsr[31:1]} ^ (b ? 32'h8020_0003 : 32'h0);
            v = {v[30:0], b};
        end
        return v;
    endfunction

    // Holds req until addr_ok, then waits for the data_ok pulse
    task automatic wait_reply(input logic is_inst);
        logic seen;
        seen = 1'b0;
        while (!seen) begin
            #1;
            seen = is_inst ? inst_resp.addr_ok : data_resp.addr_ok;
            @(posedge Clk);
            #1;
        end
        if (is_inst) inst_req.req = 1'b0;
        else data_req.req = 1'b0;
        seen = 1'b0;
        while (!seen) begin
            #1;
            seen = is_inst ? inst_resp.data_ok : data_resp.data_ok;
            @(posedge Clk);
            #1;
        end
    endtask

    task automatic fetch(input logic [31:0] addr);
        inst_exp = ref_word(addr);
        inst_req = '{req: 1'b1, wr: 1'b0, size: SIZE_WORD, addr: addr, wdata: '0};
        wait_reply(1'b1);
    endtask

    task automatic data_access(input logic wr, input access_size_e size,
                               input logic [31:0] addr, input logic [31:0] wdata);
        data_exp = ref_word(addr);
        data_is_load = !wr;
        data_req = '{req: 1'b1, wr: wr, size: size, addr: addr, wdata: wdata};
        wait_reply(1'b0);
        data_is_load = 1'b0;
    endtask

    task automatic fetch_expect_ar(input logic [31:0] addr, input logic [3:0] id,
                                   input logic [3:0] len, input logic [31:0] ar_addr);
        exp_arid = id;
        exp_arlen = len;
        exp_araddr = ar_addr;
        ar_check = 1'b1;
        fetch(addr);
        ar_check = 1'b0;
    endtask

    task automatic store_and_load(input access_size_e size, input logic [31:0] addr,
                                  input logic [31:0] wdata);
        int         nbytes;
        int         off;
        logic [3:0] strb;
        nbytes = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
        off = int'(addr[1:0]);
        // Lanes from the offset up to the last byte written
        for (int l = 0; l < 4; l++) begin
            strb[l] = (l >= off) && (l < off + nbytes);
        end
        // AXI size is log2 of bytes per beat
        exp_awsize = (nbytes == 1) ? 3'd0 : (nbytes == 2) ? 3'd1 : 3'd2;
        exp_wstrb = strb;
        aw_check = 1'b1;
        data_access(1'b1, size, addr, wdata);
        aw_check = 1'b0;
        // Store data arrives right-aligned
        for (int k = 0; k < nbytes; k++) begin
            ref_mem[addr[15:0] + 16'(k)] = wdata[k*8 +: 8];
        end
        data_access(1'b0, SIZE_WORD, {addr[31:2], 2'b00}, '0);
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %-12s %s", name, (errors == err_at_start) ? "ok" : "with errors");
        err_at_start = errors;
    endtask

    initial begin
        logic [31:0] a;
        Clk = 1'b0;
        aresetn = 1'b0;
        inst_req = '0;
        data_req = '0;
        {data_is_load, ar_check, aw_check, no_ar} = '0;
        {inst_exp, data_exp, exp_araddr} = '0;
        {exp_arid, exp_arlen, exp_awsize, exp_wstrb} = '0;
        {errors, tests, cycles, err_at_start} = '0;
        lfsr = 32'h397e;
        for (int i = 0; i < 65536; i++) begin
            ref_mem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h5a;
        end
        repeat (10) @(posedge Clk);
        #1;
        aresetn = 1'b1;
        repeat (2) @(posedge Clk);
        #1;
        end_test("reset");

        for (int i = 0; i < CACHE_WARMUP; i++) begin
            fetch_expect_ar(32'h0000_0100 + 32'(4 * i), ID_BRIDGE, 4'd0,
                            32'h0000_0100 + 32'(4 * i));
        end
        fetch_expect_ar(32'h0000_0224, ID_ICACHE, 4'd7, 32'h0000_0220);
        end_test("warmup");

        no_ar = 1'b1;
        for (int w = 0; w < LINE_WORDS; w++) begin
            fetch(32'h0000_0220 + 32'(4 * w));
        end
        no_ar = 1'b0;
        end_test("hits");

        fetch_expect_ar(32'hA000_0300, ID_BRIDGE, 4'd0, 32'hA000_0300);
        end_test("uncached");

        for (int off = 0; off < 4; off++) begin
            store_and_load(SIZE_BYTE, 32'h0000_3000 + 32'(off), 32'h0000_00c0 + 32'(off));
        end
        store_and_load(SIZE_HALF, 32'h0000_3010, 32'h0000_beef);
        store_and_load(SIZE_HALF, 32'h0000_3012, 32'h0000_1234);
        store_and_load(SIZE_WORD, 32'h0000_3020, 32'hdead_f00d);
        end_test("stores");

        for (int n = 0; n < 60; n++) begin
            a = lfsr_bits(10) << 2;
            if (lfsr_bits(1) == 32'd1) begin
                if (lfsr_bits(1) == 32'd1) a[31:29] = UNCACHED_SEG;
                fetch(a);
            end else begin
                data_access(1'b0, SIZE_WORD, a, '0);
            end
        end
        end_test("random");

        $display("tests run %0d, errors %0d", tests, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

endmodule

/* build.f */
hw/cpu_mem_pkg.sv
hw/fetch_router.sv
hw/sram_axi_bridge.sv
hw/icache.sv
hw/axi_read_arbiter.sv
hw/cpu_mem_top.sv
tests/axi_slave_mem.sv
tests/tb_cpu_mem.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -f build.f \
    --top-module tb_cpu_mem -o tb_cpu_mem

out=$(./obj_dir/tb_cpu_mem)
echo "$out"

if echo "$out" | grep -q "SIMULATION PASSED"; then
    exit 0
fi
exit 1
